// File: rtl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;   // data and address width
    localparam int REG_ADDR_W = 5;    // 32 architectural registers

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [3:0]            alu_fn_t;
    typedef logic [1:0]            pc_sel_t;
    typedef logic [1:0]            b_sel_t;
    typedef logic [2:0]            wb_sel_t;
    typedef logic [3:0]            mem_op_t;
    typedef logic [2:0]            imm_fmt_t;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    // alu function as {instr[30], funct3}
    // the branch compares reuse the compare codes
    localparam alu_fn_t ALU_ADD  = 4'b0000;  // add addi
    localparam alu_fn_t ALU_SLL  = 4'b0001;  // sll slli
    localparam alu_fn_t ALU_SLT  = 4'b0010;  // slt slti blt
    localparam alu_fn_t ALU_SLTU = 4'b0011;  // sltu sltiu bltu
    localparam alu_fn_t ALU_XOR  = 4'b0100;
    localparam alu_fn_t ALU_SRL  = 4'b0101;
    localparam alu_fn_t ALU_OR   = 4'b0110;
    localparam alu_fn_t ALU_AND  = 4'b0111;
    localparam alu_fn_t ALU_SUB  = 4'b1000;  // sub beq, bne sets bit 0
    localparam alu_fn_t ALU_BGEU = 4'b1010;
    localparam alu_fn_t ALU_BGE  = 4'b1011;  // kept off 1001 which is bne
    localparam alu_fn_t ALU_SRA  = 4'b1101;  // sra srai

    // next pc source
    localparam pc_sel_t PC_PLUS4    = 2'b00;
    localparam pc_sel_t PC_BRANCH   = 2'b01;  // cond branch or jal, pc + imm
    localparam pc_sel_t PC_JUMP_REG = 2'b10;  // jalr, rs1 + imm

    // alu operand b source
    localparam b_sel_t BSEL_REG   = 2'b00;
    localparam b_sel_t BSEL_IMM   = 2'b01;
    localparam b_sel_t BSEL_SHAMT = 2'b10;

    // writeback source
    localparam wb_sel_t WB_ALU    = 3'b000;
    localparam wb_sel_t WB_LINK   = 3'b001;  // pc + 4
    localparam wb_sel_t WB_IMM    = 3'b010;  // lui
    localparam wb_sel_t WB_PC_IMM = 3'b011;  // auipc
    localparam wb_sel_t WB_LOAD   = 3'b100;

    // memory operation codes
    localparam mem_op_t MEM_NONE = 4'b0000;
    localparam mem_op_t MEM_LB   = 4'b0001;
    localparam mem_op_t MEM_LH   = 4'b0010;
    localparam mem_op_t MEM_LW   = 4'b0011;
    localparam mem_op_t MEM_LBU  = 4'b0100;
    localparam mem_op_t MEM_LHU  = 4'b0101;
    localparam mem_op_t MEM_SB   = 4'b1110;
    localparam mem_op_t MEM_SH   = 4'b1111;
    localparam mem_op_t MEM_SW   = 4'b1000;

    // immediate formats
    localparam imm_fmt_t IMM_I = 3'b000;
    localparam imm_fmt_t IMM_S = 3'b001;
    localparam imm_fmt_t IMM_B = 3'b010;
    localparam imm_fmt_t IMM_U = 3'b011;
    localparam imm_fmt_t IMM_J = 3'b100;

endpackage

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import rv_pkg::*; (
    input  logic [6:0] i_op,
    input  logic [2:0] i_funct3,
    input  logic       i_instr_30,     // funct7 bit 5

    output pc_sel_t    o_pc_sel,
    output logic       o_we,           // regfile write
    output b_sel_t     o_b_sel,
    output alu_fn_t    o_alu_fn,
    output wb_sel_t    o_wb_sel,
    output logic       o_btype,        // conditional branch
    output logic       o_jal,
    output logic       o_jalr,
    output logic       o_lui,
    output logic       o_auipc,
    output mem_op_t    o_mem_op,
    output imm_fmt_t   o_imm_fmt
);

    logic [7:0] f3;                    // funct3 one-hot

    // opcode matches
    logic is_r;
    logic is_i;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic is_lui;
    logic is_auipc;

    // one-hot instructions
    logic add_r, sub_r, sll_r, slt_r, sltu_r, xor_r, srl_r, sra_r, or_r, and_r;
    logic addi, slti, sltiu, xori, ori, andi, slli, srli, srai;
    logic lb, lh, lw, lbu, lhu;
    logic sb, sh, sw;
    logic beq, bne, blt, bge, bltu, bgeu;
    logic jalr;

    // instruction groups
    logic alu_r;
    logic alu_i;
    logic shift_i;                     // slli srli srai
    logic load;
    logic store;
    logic branch;

    assign f3 = 8'b1 << i_funct3;

    assign is_r      = (i_op == OP_R);
    assign is_i      = (i_op == OP_I);
    assign is_load   = (i_op == OP_LOAD);
    assign is_store  = (i_op == OP_STORE);
    assign is_branch = (i_op == OP_BRANCH);
    assign is_jal    = (i_op == OP_JAL);
    assign is_jalr   = (i_op == OP_JALR);
    assign is_lui    = (i_op == OP_LUI);
    assign is_auipc  = (i_op == OP_AUIPC);

    // r-type with bit 30 only on sub and sra
    assign add_r  = is_r & f3[0] & ~i_instr_30;
    assign sub_r  = is_r & f3[0] &  i_instr_30;
    assign sll_r  = is_r & f3[1] & ~i_instr_30;
    assign slt_r  = is_r & f3[2] & ~i_instr_30;
    assign sltu_r = is_r & f3[3] & ~i_instr_30;
    assign xor_r  = is_r & f3[4] & ~i_instr_30;
    assign srl_r  = is_r & f3[5] & ~i_instr_30;
    assign sra_r  = is_r & f3[5] &  i_instr_30;
    assign or_r   = is_r & f3[6] & ~i_instr_30;
    assign and_r  = is_r & f3[7] & ~i_instr_30;

    // bit 30 is immediate data except on shifts
    assign addi  = is_i & f3[0];
    assign slti  = is_i & f3[2];
    assign sltiu = is_i & f3[3];
    assign xori  = is_i & f3[4];
    assign ori   = is_i & f3[6];
    assign andi  = is_i & f3[7];
    assign slli  = is_i & f3[1] & ~i_instr_30;
    assign srli  = is_i & f3[5] & ~i_instr_30;
    assign srai  = is_i & f3[5] &  i_instr_30;

    assign lb  = is_load & f3[0];
    assign lh  = is_load & f3[1];
    assign lw  = is_load & f3[2];
    assign lbu = is_load & f3[4];
    assign lhu = is_load & f3[5];

    assign sb = is_store & f3[0];
    assign sh = is_store & f3[1];
    assign sw = is_store & f3[2];

    assign beq  = is_branch & f3[0];
    assign bne  = is_branch & f3[1];
    assign blt  = is_branch & f3[4];
    assign bge  = is_branch & f3[5];
    assign bltu = is_branch & f3[6];
    assign bgeu = is_branch & f3[7];

    assign jalr = is_jalr & f3[0];     // funct3 must be zero

    assign alu_r   = add_r | sub_r | sll_r | slt_r | sltu_r | xor_r | srl_r | sra_r
                   | or_r | and_r;
    assign shift_i = slli | srli | srai;
    assign alu_i   = addi | slti | sltiu | xori | ori | andi | shift_i;
    assign load    = lb | lh | lw | lbu | lhu;
    assign store   = sb | sh | sw;
    assign branch  = beq | bne | blt | bge | bltu | bgeu;

    assign o_btype = branch;
    assign o_jal   = is_jal;
    assign o_jalr  = jalr;
    assign o_lui   = is_lui;
    assign o_auipc = is_auipc;

    // unknown encodings leave every term low
    assign o_we = alu_r | alu_i | load | is_jal | jalr | is_lui | is_auipc;

    assign o_pc_sel = ({2{branch | is_jal}} & PC_BRANCH)
                    | ({2{jalr}}            & PC_JUMP_REG);    // others pc + 4

    assign o_b_sel = ({2{(alu_i & ~shift_i) | load | store | jalr}} & BSEL_IMM)
                   | ({2{shift_i}}                                & BSEL_SHAMT);

    // add and addi have the all-zero code
    assign o_alu_fn = ({4{sll_r | slli}}          & ALU_SLL)
                    | ({4{slt_r | slti | blt}}    & ALU_SLT)
                    | ({4{sltu_r | sltiu | bltu}} & ALU_SLTU)
                    | ({4{xor_r | xori}}          & ALU_XOR)
                    | ({4{srl_r | srli}}          & ALU_SRL)
                    | ({4{or_r | ori}}            & ALU_OR)
                    | ({4{and_r | andi}}          & ALU_AND)
                    | ({4{sub_r | beq}}           & ALU_SUB)
                    | ({4{bne}}                   & {ALU_SUB[3:1], 1'b1})  // bne
                    | ({4{bge}}                   & ALU_BGE)
                    | ({4{bgeu}}                  & ALU_BGEU)
                    | ({4{sra_r | srai}}          & ALU_SRA);

    assign o_wb_sel = ({3{is_jal | jalr}} & WB_LINK)
                    | ({3{is_lui}}        & WB_IMM)
                    | ({3{is_auipc}}      & WB_PC_IMM)
                    | ({3{load}}          & WB_LOAD);     // alu result is code zero

    assign o_mem_op = ({4{lb}}  & MEM_LB)
                    | ({4{lh}}  & MEM_LH)
                    | ({4{lw}}  & MEM_LW)
                    | ({4{lbu}} & MEM_LBU)
                    | ({4{lhu}} & MEM_LHU)
                    | ({4{sb}}  & MEM_SB)
                    | ({4{sh}}  & MEM_SH)
                    | ({4{sw}}  & MEM_SW);

    // i format is code zero
    assign o_imm_fmt = ({3{store}}              & IMM_S)
                     | ({3{branch}}             & IMM_B)
                     | ({3{is_lui | is_auipc}}  & IMM_U)
                     | ({3{is_jal}}             & IMM_J);

endmodule

// File: rtl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import rv_pkg::*; (
    input  word_t    i_instr,
    input  imm_fmt_t i_fmt,
    output word_t    o_imm
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // sign always from instr[31]
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};     // halfword aligned
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                    i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        case (i_fmt)
            IMM_I:   o_imm = imm_i;
            IMM_S:   o_imm = imm_s;
            IMM_B:   o_imm = imm_b;
            IMM_U:   o_imm = imm_u;
            IMM_J:   o_imm = imm_j;
            default: o_imm = imm_i;   // unused codes
        endcase
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  word_t   i_a,
    input  word_t   i_b,
    input  alu_fn_t i_fn,
    input  logic    i_btype,          // evaluate branch condition
    output word_t   o_result,
    output logic    o_branch_taken
);

    logic [4:0] shamt;
    logic       lt;                   // signed a < b
    logic       ltu;                  // unsigned a < b
    logic       eq;

    assign shamt = i_b[4:0];
    assign lt    = $signed(i_a) < $signed(i_b);
    assign ltu   = i_a < i_b;
    assign eq    = i_a == i_b;

    always_comb begin
        case (i_fn)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_SLL:  o_result = i_a << shamt;
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, ltu};
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SRL:  o_result = i_a >> shamt;
            ALU_SRA:  o_result = word_t'($signed(i_a) >>> shamt);  // keeps sign
            ALU_OR:   o_result = i_a | i_b;
            ALU_AND:  o_result = i_a & i_b;
            default:  o_result = i_a + i_b;   // branch-only codes
        endcase
    end

    // branch condition, i_fn[0] is funct3[0] for beq/bne
    always_comb begin
        o_branch_taken = 1'b0;
        if (i_btype) begin
            if (i_fn[3:1] == ALU_SUB[3:1]) begin
                o_branch_taken = eq ^ i_fn[0];    // beq, bne inverts
            end else begin
                case (i_fn)
                    ALU_SLT:  o_branch_taken = lt;     // blt
                    ALU_SLTU: o_branch_taken = ltu;    // bltu
                    ALU_BGE:  o_branch_taken = ~lt;
                    ALU_BGEU: o_branch_taken = ~ltu;
                    default:  o_branch_taken = 1'b0;
                endcase
            end
        end
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile import rv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data,
    input  logic     i_we,
    input  reg_idx_t i_rd,
    input  word_t    i_wdata
);

    word_t regs [2**REG_ADDR_W];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin   // x0 never written
            regs[i_rd] <= i_wdata;
        end
    end

    // async reads, x0 hard zero
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: rtl/exec_core.sv
`timescale 1ns/1ps

module exec_core import rv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,

    input  logic     i_in_valid,
    input  word_t    i_in_pc,
    input  word_t    i_in_instr,
    output logic     o_in_ready,

    output logic     o_out_valid,
    output reg_idx_t o_out_rd,
    output logic     o_out_we,
    output word_t    o_out_wdata,
    output word_t    o_out_next_pc,
    output mem_op_t  o_out_mem_op,
    output word_t    o_out_mem_addr,
    output word_t    o_out_mem_wdata,
    input  logic     i_out_ready
);

    // decoder outputs
    pc_sel_t  pc_sel;
    logic     dec_we;
    b_sel_t   b_sel;
    alu_fn_t  alu_fn;
    wb_sel_t  wb_sel;
    logic     btype;
    logic     jal;
    logic     jalr;
    logic     lui;
    logic     auipc;
    mem_op_t  mem_op;
    imm_fmt_t imm_fmt;

    reg_idx_t rd;
    reg_idx_t rs1_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    word_t    op_b;
    word_t    alu_result;
    logic     taken;
    word_t    pc_plus4;
    word_t    pc_imm;
    word_t    rs1_imm;          // load/store address and jalr base
    word_t    jump_target;
    word_t    next_pc;
    word_t    wdata;
    logic     in_fire;
    logic     out_fire;

    assign rd = i_in_instr[11:7];
    // rs1 field holds immediate bits for u and j formats, read x0 there
    assign rs1_idx = (lui | auipc | jal) ? '0 : i_in_instr[19:15];

    instr_decoder dec_i (
        .i_op       (i_in_instr[6:0]),
        .i_funct3   (i_in_instr[14:12]),
        .i_instr_30 (i_in_instr[30]),
        .o_pc_sel   (pc_sel),
        .o_we       (dec_we),
        .o_b_sel    (b_sel),
        .o_alu_fn   (alu_fn),
        .o_wb_sel   (wb_sel),
        .o_btype    (btype),
        .o_jal      (jal),
        .o_jalr     (jalr),
        .o_lui      (lui),
        .o_auipc    (auipc),
        .o_mem_op   (mem_op),
        .o_imm_fmt  (imm_fmt)
    );

    imm_gen imm_i (
        .i_instr (i_in_instr),
        .i_fmt   (imm_fmt),
        .o_imm   (imm)
    );

    regfile rf_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1      (rs1_idx),
        .i_rs2      (i_in_instr[24:20]),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (out_fire & o_out_we),   // commit on output handshake
        .i_rd       (o_out_rd),
        .i_wdata    (o_out_wdata)
    );

    // operand b
    always_comb begin
        case (b_sel)
            BSEL_IMM:   op_b = imm;
            BSEL_SHAMT: op_b = word_t'(i_in_instr[24:20]);   // drops funct7 bits
            default:    op_b = rs2_data;
        endcase
    end

    alu alu_i (
        .i_a            (rs1_data),
        .i_b            (op_b),
        .i_fn           (alu_fn),
        .i_btype        (btype),
        .o_result       (alu_result),
        .o_branch_taken (taken)
    );

    assign pc_plus4    = i_in_pc + 32'd4;
    assign pc_imm      = i_in_pc + imm;
    assign rs1_imm     = rs1_data + imm;
    assign jump_target = jalr ? {rs1_imm[XLEN-1:1], 1'b0} : pc_imm;  // jalr clears bit 0

    always_comb begin
        case (pc_sel)
            PC_BRANCH:   next_pc = (jal | taken) ? jump_target : pc_plus4;
            PC_JUMP_REG: next_pc = jump_target;
            default:     next_pc = pc_plus4;
        endcase
    end

    // writeback value, loads return zero until a data memory exists
    always_comb begin
        case (wb_sel)
            WB_LINK:   wdata = pc_plus4;
            WB_IMM:    wdata = imm;
            WB_PC_IMM: wdata = pc_imm;
            WB_LOAD:   wdata = '0;
            default:   wdata = alu_result;
        endcase
    end

    // single slot, accept only when output register is empty
    assign o_in_ready = ~o_out_valid;
    assign in_fire    = i_in_valid & o_in_ready;
    assign out_fire   = o_out_valid & i_out_ready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_out_valid <= 1'b0;
        end else if (in_fire) begin
            o_out_valid <= 1'b1;
        end else if (out_fire) begin
            o_out_valid <= 1'b0;
        end
    end

    // result payload, held while stalled
    always_ff @(posedge i_clk) begin
        if (in_fire) begin
            o_out_rd        <= rd;
            o_out_we        <= dec_we & (rd != '0);   // no write to x0
            o_out_wdata     <= wdata;
            o_out_next_pc   <= next_pc;
            o_out_mem_op    <= mem_op;
            o_out_mem_addr  <= rs1_imm;
            o_out_mem_wdata <= rs2_data;
        end
    end

endmodule

// File: testbench/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core import rv_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 4;
    localparam int CYCLES_PER_LINE = 60;       // watchdog budget per instruction
    localparam int TAG_W           = 8 * 24;   // test name, up to 24 chars
    localparam logic [31:0] SEED   = 32'd92584;
    localparam STIM_FILE           = "testbench/exec_stimulus.txt";

    logic     i_clk;
    logic     i_rst_n;
    logic     i_in_valid;
    word_t    i_in_pc;
    word_t    i_in_instr;
    logic     o_in_ready;
    logic     o_out_valid;
    reg_idx_t o_out_rd;
    logic     o_out_we;
    word_t    o_out_wdata;
    word_t    o_out_next_pc;
    mem_op_t  o_out_mem_op;
    word_t    o_out_mem_addr;
    word_t    o_out_mem_wdata;
    logic     i_out_ready;

    // expected results, one entry per stimulus line
    logic [TAG_W-1:0] tag_q[$];
    word_t            pc_q[$];
    word_t            instr_q[$];
    reg_idx_t         rd_q[$];
    logic             we_q[$];
    word_t            wdata_q[$];
    word_t            next_q[$];
    mem_op_t          op_q[$];
    word_t            addr_q[$];
    word_t            sdata_q[$];
    int               n_lines = 0;

    exec_core dut_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_in_valid      (i_in_valid),
        .i_in_pc         (i_in_pc),
        .i_in_instr      (i_in_instr),
        .o_in_ready      (o_in_ready),
        .o_out_valid     (o_out_valid),
        .o_out_rd        (o_out_rd),
        .o_out_we        (o_out_we),
        .o_out_wdata     (o_out_wdata),
        .o_out_next_pc   (o_out_next_pc),
        .o_out_mem_op    (o_out_mem_op),
        .o_out_mem_addr  (o_out_mem_addr),
        .o_out_mem_wdata (o_out_mem_wdata),
        .i_out_ready     (i_out_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input logic [TAG_W-1:0] tag, input string field,
                              input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error %0s %0s: expected %h, actual %h",
                                        tag, field, exp, act));
        end
    endtask

    task automatic check_reg(input logic [TAG_W-1:0] tag, input string field,
                             input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error %0s %0s: expected %0d, actual %0d",
                                        tag, field, exp, act));
        end
    endtask

    task automatic check_mem_op(input logic [TAG_W-1:0] tag, input string field,
                                input mem_op_t exp, input mem_op_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error %0s %0s: expected %h, actual %h",
                                        tag, field, exp, act));
        end
    endtask

    task automatic check_bit(input logic [TAG_W-1:0] tag, input string field,
                             input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error %0s %0s: expected %b, actual %b",
                                        tag, field, exp, act));
        end
    endtask

    task automatic load_stimulus();
        int               fd;
        int               n;
        string            line;
        logic [TAG_W-1:0] tag;
        logic [31:0]      f_pc, f_instr, f_rd, f_we, f_wdata;
        logic [31:0]      f_next, f_op, f_addr, f_sdata;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stop_with_failure("could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin   // skip comments
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", tag, f_pc, f_instr,
                                f_rd, f_we, f_wdata, f_next, f_op, f_addr, f_sdata);
                    if (n == 10) begin                              // blank lines drop out
                        tag_q.push_back(tag);
                        pc_q.push_back(f_pc);
                        instr_q.push_back(f_instr);
                        rd_q.push_back(reg_idx_t'(f_rd));
                        we_q.push_back(f_we[0]);
                        wdata_q.push_back(f_wdata);
                        next_q.push_back(f_next);
                        op_q.push_back(mem_op_t'(f_op));
                        addr_q.push_back(f_addr);
                        sdata_q.push_back(f_sdata);
                    end
                end
            end
            $fclose(fd);
            n_lines = tag_q.size();
            if (n_lines == 0) begin
                stop_with_failure("the stimulus file holds no instructions");
            end
        end
    endtask

    // every output field against the hand-worked line
    task automatic compare_result(input int i);
        check_reg(tag_q[i], "rd", rd_q[i], o_out_rd);
        check_bit(tag_q[i], "we", we_q[i], o_out_we);
        check_word(tag_q[i], "next_pc", next_q[i], o_out_next_pc);
        check_mem_op(tag_q[i], "mem_op", op_q[i], o_out_mem_op);
        if (we_q[i]) begin
            check_word(tag_q[i], "wdata", wdata_q[i], o_out_wdata);   // only when written
        end
        if (op_q[i] != MEM_NONE) begin
            check_word(tag_q[i], "mem_addr", addr_q[i], o_out_mem_addr);
        end
        if (op_q[i] inside {MEM_SB, MEM_SH, MEM_SW}) begin
            check_word(tag_q[i], "mem_wdata", sdata_q[i], o_out_mem_wdata);  // stores only
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] rnd;
        logic        accepted;
        rnd = SEED;
        for (int i = 0; i < n_lines; i++) begin
            rnd = xorshift32(rnd);
            if (rnd[2:0] == 3'd0) begin
                repeat (1 + rnd[4:3]) @(negedge i_clk);   // idle gap
            end
            i_in_valid = 1'b1;
            i_in_pc    = pc_q[i];
            i_in_instr = instr_q[i];
            do begin
                accepted = o_in_ready;                    // stable mid cycle
                @(negedge i_clk);
            end while (!accepted);
            i_in_valid = 1'b0;
        end
    endtask

    task automatic collect_outputs();
        logic [31:0] rnd;
        int          got;
        logic        stalled;
        rnd     = xorshift32(xorshift32(SEED));           // offset from driver stream
        got     = 0;
        stalled = 1'b0;
        while (got < n_lines) begin
            @(negedge i_clk);
            if (stalled && !o_out_valid) begin
                stop_with_failure("output valid dropped while the output was stalled");
            end
            rnd         = xorshift32(rnd);
            i_out_ready = (rnd[1:0] != 2'b00);            // about one stall in four
            stalled     = o_out_valid & ~i_out_ready;
            if (o_out_valid && i_out_ready) begin         // handshake at next posedge
                compare_result(got);
                got++;
            end
        end
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_in_valid  = 1'b0;
        i_in_pc     = '0;
        i_in_instr  = '0;
        i_out_ready = 1'b0;
        load_stimulus();
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        check_bit("after_reset", "out_valid", 1'b0, o_out_valid);
        check_bit("after_reset", "in_ready", 1'b1, o_in_ready);
        fork
            drive_inputs();
            collect_outputs();
        join
        repeat (3) @(negedge i_clk);
        if (o_out_valid) begin
            stop_with_failure("an extra output appeared after the last instruction");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (n_lines > 0);
        repeat (RESET_CYCLES + n_lines * CYCLES_PER_LINE) @(posedge i_clk);
        stop_with_failure("timeout, outputs stopped arriving from the core");
    end

endmodule

// File: testbench/exec_stimulus.txt
# name pc instr rd we wdata next_pc mem_op mem_addr mem_wdata (all hex but name)
# wdata checked when we=1, mem_addr for loads and stores, mem_wdata for stores
addi_x1         00000100 00500093 01 1 00000005 00000104 0 00000000 00000000
addi_x2_neg     00000104 ffd00113 02 1 fffffffd 00000108 0 00000000 00000000
add             00000108 002081b3 03 1 00000002 0000010c 0 00000000 00000000
sub             0000010c 40208233 04 1 00000008 00000110 0 00000000 00000000
slt             00000110 001122b3 05 1 00000001 00000114 0 00000000 00000000
sltu            00000114 00113333 06 1 00000000 00000118 0 00000000 00000000
sra_neg         00000118 401153b3 07 1 ffffffff 0000011c 0 00000000 00000000
srl             0000011c 00115433 08 1 07ffffff 00000120 0 00000000 00000000
srai_neg        00000120 40115493 09 1 fffffffe 00000124 0 00000000 00000000
xori            00000124 0f00c513 0a 1 000000f5 00000128 0 00000000 00000000
andi            00000128 03c57593 0b 1 00000034 0000012c 0 00000000 00000000
or              0000012c 00326633 0c 1 0000000a 00000130 0 00000000 00000000
sll             00000130 003096b3 0d 1 00000014 00000134 0 00000000 00000000
slti            00000134 00012713 0e 1 00000001 00000138 0 00000000 00000000
sltiu           00000138 fff0b793 0f 1 00000001 0000013c 0 00000000 00000000
addi_x0         0000013c 00708013 00 0 00000000 00000140 0 00000000 00000000
add_read_x0     00000140 00100833 10 1 00000005 00000144 0 00000000 00000000
beq_taken       00000144 01008863 10 0 00000000 00000154 0 00000000 00000000
beq_not         00000148 00208863 10 0 00000000 0000014c 0 00000000 00000000
bne_taken_back  0000014c fe209ce3 19 0 00000000 00000144 0 00000000 00000000
bne_not         00000150 01009863 10 0 00000000 00000154 0 00000000 00000000
blt_taken       00000154 00114863 10 0 00000000 00000164 0 00000000 00000000
blt_not         00000158 0020c863 10 0 00000000 0000015c 0 00000000 00000000
bge_taken       0000015c 0020d863 10 0 00000000 0000016c 0 00000000 00000000
bge_not         00000160 00115863 10 0 00000000 00000164 0 00000000 00000000
bltu_taken      00000164 0020e863 10 0 00000000 00000174 0 00000000 00000000
bltu_not        00000168 00116863 10 0 00000000 0000016c 0 00000000 00000000
bgeu_taken_back 0000016c fe117ce3 19 0 00000000 00000164 0 00000000 00000000
bgeu_not        00000170 0020f863 10 0 00000000 00000174 0 00000000 00000000
jal_fwd         00000174 020008ef 11 1 00000178 00000194 0 00000000 00000000
jal_back        00000178 ff1ff96f 12 1 0000017c 00000168 0 00000000 00000000
jalr            0000017c 010089e7 13 1 00000180 00000014 0 00000000 00000000
jalr_odd        00000180 00388a67 14 1 00000184 0000017a 0 00000000 00000000
lui             00000184 12345ab7 15 1 12345000 00000188 0 00000000 00000000
auipc           00000188 00001b17 16 1 00001188 0000018c 0 00000000 00000000
auipc_neg       0000018c fffffb97 17 1 fffff18c 00000190 0 00000000 00000000
lb              00000190 001a8c03 18 1 00000000 00000194 1 12345001 00000000
lh_neg          00000194 ffea9c83 19 1 00000000 00000198 2 12344ffe 00000000
lw              00000198 008aad03 1a 1 00000000 0000019c 3 12345008 00000000
lbu             0000019c 003acd83 1b 1 00000000 000001a0 4 12345003 00000000
lhu             000001a0 006ade03 1c 1 00000000 000001a4 5 12345006 00000000
sb              000001a4 00aa8223 04 0 00000000 000001a8 e 12345004 000000f5
sh_neg          000001a8 fe7a9e23 1c 0 00000000 000001ac f 12344ffc ffffffff
sw              000001ac 0556a023 00 0 00000000 000001b0 8 00000054 12345000
add_after_load  000001b0 010c0eb3 1d 1 00000005 000001b4 0 00000000 00000000

// File: all.f
rtl/rv_pkg.sv
rtl/instr_decoder.sv
rtl/imm_gen.sv
rtl/alu.sv
rtl/regfile.sv
rtl/exec_core.sv
testbench/tb_exec_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the exec_core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_exec_core -o sim_exec

# the simulator exits non-zero on a fatal stop, the log decides the result
./obj_dir/sim_exec | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
